/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* source/rv_commit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_commit
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  decoded_t            dec,
    input  exec_t               ex,
    output logic [`RV_XLEN-1:0] pc,
    output wb_t                 wb
);

    logic [`RV_XLEN-1:0] snpc;
    logic                is_link;
    logic                writes_rd;

    assign snpc    = pc + `RV_XLEN'd4;
    assign is_link = (dec.opcode == OPC_JAL) || (dec.opcode == OPC_JALR);

    always_comb begin
        case (dec.inst_type)
            TYPE_R, TYPE_I, TYPE_U, TYPE_J: writes_rd = 1'b1;
            default:                        writes_rd = 1'b0;  // branches, no-ops
        endcase
    end

    assign wb.en   = writes_rd && (dec.rd != '0) && !reset;
    assign wb.rd   = dec.rd;
    assign wb.data = is_link ? snpc : ex.alu_result;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= `RV_RESET_PC;
        else if (ex.jump_en)
            pc <= ex.jump_target;
        else
            pc <= snpc;
    end

endmodule

`default_nettype wire

/* source/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  inst_word_u          inst,  // must be the word at pc
    output logic [`RV_XLEN-1:0] pc,
    output wb_t                 wb
);

    decoded_t            dec;
    exec_t               ex;
    logic [`RV_XLEN-1:0] src1;
    logic [`RV_XLEN-1:0] src2;

    rv_decode u_decode (
        .inst (inst),
        .dec  (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .wb     (wb),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (src1),
        .rdata2 (src2)
    );

    rv_execute u_execute (
        .dec  (dec),
        .src1 (src1),
        .src2 (src2),
        .pc   (pc),
        .ex   (ex)
    );

    rv_commit u_commit (
        .clk   (clk),
        .reset (reset),
        .dec   (dec),
        .ex    (ex),
        .pc    (pc),
        .wb    (wb)
    );

endmodule

`default_nettype wire

/* source/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_decode
    import rv_pkg::*;
(
    input  inst_word_u inst,
    output decoded_t   dec
);

    logic [6:0]          funct7;
    opcode_e             opcode;
    inst_type_e          inst_type;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_u;

    assign funct7 = inst.fields.funct7;
    assign opcode = opcode_e'(inst.fields.opcode);

    // scattered immediates rebuilt from the register view
    assign imm_i = {{20{funct7[6]}}, funct7, inst.fields.rs2};
    assign imm_b = {{20{funct7[6]}}, inst.fields.rd[0], funct7[5:0],
                    inst.fields.rd[4:1], 1'b0};
    assign imm_j = {{12{funct7[6]}}, inst.fields.rs1, inst.fields.funct3,
                    inst.fields.rs2[0], funct7[5:0], inst.fields.rs2[4:1], 1'b0};
    assign imm_u = {inst.upper.imm, 12'b0};

    assign dec.inst_type = inst_type;
    assign dec.opcode    = opcode;
    assign dec.funct3    = inst.fields.funct3;
    assign dec.rd        = inst.upper.rd;
    assign dec.rs1       = inst.fields.rs1;
    assign dec.rs2       = inst.fields.rs2;

    always_comb begin
        case (opcode)
            OPC_OP:             inst_type = TYPE_R;
            OPC_OP_IMM,
            OPC_JALR:           inst_type = TYPE_I;
            OPC_BRANCH:         inst_type = TYPE_B;
            OPC_LUI, OPC_AUIPC: inst_type = TYPE_U;
            OPC_JAL:            inst_type = TYPE_J;
            default:            inst_type = TYPE_N;  // load, store, system...
        endcase
    end

    always_comb begin
        case (inst_type)
            TYPE_I:  dec.imm = imm_i;
            TYPE_B:  dec.imm = imm_b;
            TYPE_U:  dec.imm = imm_u;
            TYPE_J:  dec.imm = imm_j;
            default: dec.imm = '0;
        endcase
    end

    always_comb begin
        dec.alu_op = ALU_ADD;
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (inst.fields.funct3)
                3'b000: begin
                    // addi has no subtract form
                    if (inst_type == TYPE_R && funct7[5])
                        dec.alu_op = ALU_SUB;
                end
                3'b001: dec.alu_op = ALU_SLL;
                3'b010: dec.alu_op = ALU_SLT;
                3'b011: dec.alu_op = ALU_SLTU;
                3'b100: dec.alu_op = ALU_XOR;
                3'b101: dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: dec.alu_op = ALU_OR;
                default: dec.alu_op = ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width
`define RV_XLEN 32

// register file geometry
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

`endif

/* source/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_execute
    import rv_pkg::*;
(
    input  decoded_t            dec,
    input  logic [`RV_XLEN-1:0] src1,
    input  logic [`RV_XLEN-1:0] src2,
    input  logic [`RV_XLEN-1:0] pc,
    output exec_t               ex
);

    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [4:0]          shamt;
    logic                take;

    // operand select
    always_comb begin
        alu_a = src1;
        alu_b = src2;
        case (dec.inst_type)
            TYPE_I: alu_b = dec.imm;
            TYPE_U: begin
                alu_a = (dec.opcode == OPC_LUI) ? '0 : pc;
                alu_b = dec.imm;
            end
            TYPE_B, TYPE_J: begin
                alu_a = pc;  // target = pc + offset
                alu_b = dec.imm;
            end
            default: ;
        endcase
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  alu_y = alu_a - alu_b;
            ALU_SLL:  alu_y = alu_a << shamt;
            ALU_SLT:  alu_y = {{(`RV_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_y = {{(`RV_XLEN-1){1'b0}}, alu_a < alu_b};
            ALU_XOR:  alu_y = alu_a ^ alu_b;
            ALU_SRL:  alu_y = alu_a >> shamt;
            ALU_SRA:  alu_y = $unsigned($signed(alu_a) >>> shamt);
            ALU_OR:   alu_y = alu_a | alu_b;
            ALU_AND:  alu_y = alu_a & alu_b;
            default:  alu_y = alu_a + alu_b;
        endcase
    end

    // branch condition on the raw register values
    always_comb begin
        case (dec.funct3)
            3'b000:  take = (src1 == src2);
            3'b001:  take = (src1 != src2);
            3'b100:  take = ($signed(src1) < $signed(src2));
            3'b101:  take = ($signed(src1) >= $signed(src2));
            3'b110:  take = (src1 < src2);
            3'b111:  take = (src1 >= src2);
            default: take = 1'b0;
        endcase
    end

    assign ex.alu_result = alu_y;

    always_comb begin
        ex.jump_en     = 1'b0;
        ex.jump_target = alu_y;
        case (dec.inst_type)
            TYPE_I: begin
                if (dec.opcode == OPC_JALR) begin
                    ex.jump_en     = 1'b1;
                    ex.jump_target = {alu_y[`RV_XLEN-1:1], 1'b0};
                end
            end
            TYPE_J:  ex.jump_en = 1'b1;
            TYPE_B:  ex.jump_en = take;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_pkg.sv */
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N  // no-op, nothing written
    } inst_type_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // same word, register layout or upper-immediate layout
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } fields;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } upper;
    } inst_word_u;

    typedef struct packed {
        inst_type_e               inst_type;
        opcode_e                  opcode;
        logic [2:0]               funct3;
        logic [`RV_REG_AW-1:0]    rd;
        logic [`RV_REG_AW-1:0]    rs1;
        logic [`RV_REG_AW-1:0]    rs2;
        logic [`RV_XLEN-1:0]      imm;
        alu_op_e                  alu_op;
    } decoded_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] alu_result;
        logic                jump_en;
        logic [`RV_XLEN-1:0] jump_target;
    } exec_t;

    typedef struct packed {
        logic                  en;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
    } wb_t;

endpackage

`default_nettype wire

/* source/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_regfile
    import rv_pkg::*;
(
    input  logic                  clk,
    input  wb_t                   wb,
    input  logic [`RV_REG_AW-1:0] raddr1,
    input  logic [`RV_REG_AW-1:0] raddr2,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (wb.en)
            regs[wb.rd] <= wb.data;
    end

    // x0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;  // same skew as the stimulus
    end

endmodule

`default_nettype wire

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module tb_rv_core
    import rv_pkg::*;
();

    typedef logic [`RV_NUM_REGS-1:0][`RV_XLEN-1:0] arch_regs_t;

    localparam int RESET_WAIT = 20;
    localparam int MAX_CYCLES = 2000;

    logic                clk;
    logic                reset;
    inst_word_u          inst;
    logic [`RV_XLEN-1:0] pc;
    wb_t                 wb;
    logic [31:0]         rng_state = 32'h6f80393f;
    logic                stim_done = 1'b0;

    tb_clock clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    rv_core rv_core_inst (
        .clk   (clk),
        .reset (reset),
        .inst  (inst),
        .pc    (pc),
        .wb    (wb)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "run stopped at %0d ns", $time);
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        // rd and data only matter when a write is expected
        if (got.en !== exp.en || (exp.en && (got.rd !== exp.rd || got.data !== exp.data)))
            fail_run($sformatf("ERR t=%0d ns wb got=%h expected=%h", $time, got, exp));
    endtask

    task automatic check_pc(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("ERR t=%0d ns pc got=%h expected=%h", $time, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] gen_op_imm();
        logic [31:0] r;
        logic [11:0] imm;
        r = next_rand();
        case (r[14:12])
            3'b001:  imm = {7'b0, r[24:20]};
            3'b101:  imm = {r[30] ? 7'b0100000 : 7'b0, r[24:20]};  // srai or srli
            default: imm = r[31:20];
        endcase
        return enc_i(imm, r[19:15], r[14:12], r[11:7], OPC_OP_IMM);
    endfunction

    function automatic logic [31:0] gen_op();
        logic [31:0] r;
        logic        alt;
        r = next_rand();
        alt = r[30] && (r[14:12] == 3'b000 || r[14:12] == 3'b101);
        return enc_r(alt ? 7'b0100000 : 7'b0, r[24:20], r[19:15], r[14:12], r[11:7]);
    endfunction

    function automatic logic [31:0] gen_upper();
        logic [31:0] r;
        r = next_rand();
        return {r[31:12], r[11:7], r[0] ? OPC_LUI : OPC_AUIPC};
    endfunction

    function automatic logic [31:0] gen_branch();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [4:0]  rs2;
        logic [12:0] off;
        r = next_rand();
        f3 = r[14:12];
        if (f3 == 3'b010 || f3 == 3'b011)
            f3 = f3 ^ 3'b110;  // no branch there, use blt/bge
        rs2 = r[31] ? r[19:15] : r[24:20];  // equal operands now and then
        off = {{5{r[6]}}, r[6:1], 2'b00};
        return {off[12], off[10:5], rs2, r[19:15], f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] gen_jump();
        logic [31:0] r;
        logic [20:0] off;
        r = next_rand();
        off = {{10{r[30]}}, r[30:21], 1'b0};
        if (r[0])
            return {off[20], off[10:1], off[11], off[19:12], r[11:7], OPC_JAL};
        return enc_i(r[31:20], r[19:15], 3'b000, r[11:7], OPC_JALR);
    endfunction

    function automatic logic [31:0] gen_other();
        logic [31:0] r;
        r = next_rand();
        case (r[1:0])
            2'b00:   return {r[31:7], 7'b0000011};  // load
            2'b01:   return {r[31:7], 7'b0100011};  // store
            default: return {r[31:7], 7'b1110011};
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return (sa < sb) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt)
                    return sa >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // architectural step for one instruction
    function automatic void ref_step(input arch_regs_t regs, input logic [31:0] cur_pc,
                                     input logic [31:0] w, output wb_t exp_wb,
                                     output logic [31:0] next_pc);
        logic [31:0]        a;
        logic [31:0]        b;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        imm_i;
        logic [31:0]        imm_b;
        logic [31:0]        imm_j;
        logic               taken;
        a = regs[w[19:15]];
        b = regs[w[24:20]];
        sa = a;
        sb = b;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        exp_wb.en = 1'b0;
        exp_wb.rd = w[11:7];
        exp_wb.data = '0;
        next_pc = cur_pc + 32'd4;
        case (w[6:0])
            OPC_OP: begin
                exp_wb.en = 1'b1;
                exp_wb.data = alu_ref(w[14:12], w[30], a, b);
            end
            OPC_OP_IMM: begin
                exp_wb.en = 1'b1;
                exp_wb.data = alu_ref(w[14:12], w[14:12] == 3'b101 && w[30], a, imm_i);
            end
            OPC_LUI: begin
                exp_wb.en = 1'b1;
                exp_wb.data = {w[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                exp_wb.en = 1'b1;
                exp_wb.data = cur_pc + {w[31:12], 12'b0};
            end
            OPC_JAL: begin
                exp_wb.en = 1'b1;
                exp_wb.data = cur_pc + 32'd4;
                next_pc = cur_pc + imm_j;
            end
            OPC_JALR: begin
                exp_wb.en = 1'b1;
                exp_wb.data = cur_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                case (w[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = (sa < sb);
                    3'b101:  taken = (sa >= sb);
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken)
                    next_pc = cur_pc + imm_b;
            end
            default: ;
        endcase
        if (w[11:7] == 5'd0)
            exp_wb.en = 1'b0;
    endfunction

    // call right after a rising edge
    task automatic drive(input logic [31:0] w);
        #1;
        inst = w;
        @(posedge clk);
    endtask

    initial begin : stimulus
        int          n;
        logic [31:0] r;
        inst = enc_i(12'd1, 5'd0, 3'b000, 5'd1, OPC_OP_IMM);  // writes x1 once out of reset
        for (n = 0; n < RESET_WAIT; n++) begin
            @(posedge clk);
            if (!reset)
                break;
        end
        if (reset)
            fail_run("reset was never released");
        for (n = 1; n < `RV_NUM_REGS; n++) begin
            r = next_rand();
            drive(enc_i(r[11:0], 5'd0, 3'b000, n[4:0], OPC_OP_IMM));
        end
        repeat (40) drive(gen_op_imm());
        drive(enc_r(7'b0100000, 5'd4, 5'd3, 3'b000, 5'd8));  // sub
        drive(enc_r(7'b0100000, 5'd6, 5'd5, 3'b101, 5'd9));  // sra
        repeat (60) drive(gen_op());
        drive(enc_r(7'b0, 5'd2, 5'd1, 3'b000, 5'd0));
        drive(enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd7));  // x0 still reads zero
        repeat (20) drive(gen_upper());
        repeat (60) drive(gen_branch());
        repeat (30) drive(gen_jump());
        repeat (12) drive(gen_other());
        #1;
        stim_done = 1'b1;
    end

    initial begin : compare
        arch_regs_t          model_regs;
        logic [`RV_XLEN-1:0] model_pc;
        logic [`RV_XLEN-1:0] next_pc;
        wb_t                 exp_wb;
        int                  n;
        model_regs = '0;
        for (n = 0; n < RESET_WAIT; n++) begin
            @(posedge clk);
            #7;
            if (!reset)
                break;
            check_wb(wb, '0);
        end
        if (reset)
            fail_run("reset still high when checking should start");
        model_pc = `RV_RESET_PC;
        for (n = 0; n < MAX_CYCLES && !stim_done; n++) begin
            check_pc(pc, model_pc);
            ref_step(model_regs, model_pc, inst, exp_wb, next_pc);
            check_wb(wb, exp_wb);
            if (exp_wb.en)
                model_regs[exp_wb.rd] = exp_wb.data;
            model_pc = next_pc;
            @(posedge clk);
            #7;  // 1 ns before the next edge
        end
        if (stim_done) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_run($sformatf("stimulus did not finish within %0d cycles", MAX_CYCLES));
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/rv_pkg.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_regfile.sv
source/rv_commit.sv
source/rv_core.sv
tb/tb_clock.sv
tb/tb_rv_core.sv
